// ==== logic/arf_pkg.sv ====
//************************************************
// arf_pkg
// sizes, index and payload types for the
// architectural register files (GPR and FPR)
//************************************************

`default_nettype none

package arf_pkg;

   localparam int NUM_REGS     = 32;            // registers per file
   localparam int REG_ADDR_W   = 5;             // log2 of NUM_REGS
   localparam int XLEN         = 32;            // integer word
   localparam int FLEN         = 32;            // single precision fp word

   localparam int NUM_RD_PORTS = 4;             // i0 rs1, i0 rs2, i1 rs1, i1 rs2
   localparam int GPR_WR_PORTS = 3;             // i0, i1, nbl, lowest priority first
   localparam int FPR_WR_PORTS = 2;             // i0, nbl, lowest priority first

   //************************************************
   // port slots
   //************************************************
   localparam int RD_I0_RS1    = 0;
   localparam int RD_I0_RS2    = 1;
   localparam int RD_I1_RS1    = 2;
   localparam int RD_I1_RS2    = 3;

   localparam int GPR_WP_I0    = 0;             // slot-0 writeback
   localparam int GPR_WP_I1    = 1;             // slot-1 writeback
   localparam int GPR_WP_NBL   = 2;             // load return, wins ties

   localparam int FPR_WP_I0    = 0;
   localparam int FPR_WP_NBL   = 1;             // load return, wins ties

   typedef logic [REG_ADDR_W-1:0] reg_addr_t;   // register index
   typedef logic [XLEN-1:0]       gpr_word_t;   // integer payload
   typedef logic [FLEN-1:0]       fpr_word_t;   // fp payload

endpackage

`default_nettype wire

// ==== logic/arf_write_router.sv ====
//************************************************
// arf_write_router
// steers the three writeback sources onto the
// GPR and FPR write ports, drops GPR x0 writes
//************************************************

`timescale 1ns/1ps
`default_nettype none

module arf_write_router (
   input  logic                  i0_wen,        // slot-0 writeback valid
   input  logic                  i0_fp,         // slot-0 targets fpr
   input  arf_pkg::reg_addr_t    i0_waddr,
   input  arf_pkg::gpr_word_t    i0_wdata,

   input  logic                  i1_wen,        // slot-1 writeback, gpr only
   input  arf_pkg::reg_addr_t    i1_waddr,
   input  arf_pkg::gpr_word_t    i1_wdata,

   input  logic                  nbl_wen,       // nonblock load data back
   input  logic                  nbl_fp,        // load goes to fpr
   input  arf_pkg::reg_addr_t    nbl_waddr,
   input  arf_pkg::gpr_word_t    nbl_wdata,

   output logic [arf_pkg::GPR_WR_PORTS-1:0] gpr_wen,
   output arf_pkg::reg_addr_t    gpr_waddr [arf_pkg::GPR_WR_PORTS],
   output arf_pkg::gpr_word_t    gpr_wdata [arf_pkg::GPR_WR_PORTS],

   output logic [arf_pkg::FPR_WR_PORTS-1:0] fpr_wen,
   output arf_pkg::reg_addr_t    fpr_waddr [arf_pkg::FPR_WR_PORTS],
   output arf_pkg::fpr_word_t    fpr_wdata [arf_pkg::FPR_WR_PORTS]
);

   import arf_pkg::*;

   //************************************************
   // gpr side, x0 writes never leave the router
   //************************************************
   assign gpr_wen[GPR_WP_I0]    = i0_wen & ~i0_fp & (i0_waddr != '0);
   assign gpr_wen[GPR_WP_I1]    = i1_wen & (i1_waddr != '0);       // no fp path on slot 1
   assign gpr_wen[GPR_WP_NBL]   = nbl_wen & ~nbl_fp & (nbl_waddr != '0);

   assign gpr_waddr[GPR_WP_I0]  = i0_waddr;
   assign gpr_waddr[GPR_WP_I1]  = i1_waddr;
   assign gpr_waddr[GPR_WP_NBL] = nbl_waddr;

   assign gpr_wdata[GPR_WP_I0]  = i0_wdata;
   assign gpr_wdata[GPR_WP_I1]  = i1_wdata;
   assign gpr_wdata[GPR_WP_NBL] = nbl_wdata;

   //************************************************
   // fpr side, f0 is a normal register
   //************************************************
   assign fpr_wen[FPR_WP_I0]    = i0_wen & i0_fp;
   assign fpr_wen[FPR_WP_NBL]   = nbl_wen & nbl_fp;

   assign fpr_waddr[FPR_WP_I0]  = i0_waddr;
   assign fpr_waddr[FPR_WP_NBL] = nbl_waddr;

   assign fpr_wdata[FPR_WP_I0]  = i0_wdata;       // XLEN == FLEN
   assign fpr_wdata[FPR_WP_NBL] = nbl_wdata;

endmodule

`default_nettype wire

// ==== logic/arf_regfile.sv ====
//************************************************
// arf_regfile
// NUM_REGS entry register array, generic payload
// prioritized multi-port write, four comb reads
// later write port wins on an index collision
//************************************************

`timescale 1ns/1ps
`default_nettype none

module arf_regfile #(
   parameter type data_t   = arf_pkg::gpr_word_t,     // payload of one register
   parameter int  WR_PORTS = arf_pkg::GPR_WR_PORTS    // write ports, lowest prio first
) (
   input  logic                  clk,
   input  logic                  rst_n,               // async, active low

   input  logic [WR_PORTS-1:0]   wen,
   input  arf_pkg::reg_addr_t    waddr [WR_PORTS],
   input  data_t                 wdata [WR_PORTS],

   input  arf_pkg::reg_addr_t    raddr [arf_pkg::NUM_RD_PORTS],
   output data_t                 rdata [arf_pkg::NUM_RD_PORTS]
);

   import arf_pkg::*;

   data_t regs     [NUM_REGS];                        // architectural state
   data_t regs_nxt [NUM_REGS];                        // state after this edge

   //************************************************
   // write merge
   //************************************************
   always_comb begin
      regs_nxt = regs;                                // hold by default
      for (int p = 0; p < WR_PORTS; p++) begin        // ascending, last match wins
         if (wen[p]) begin
            regs_nxt[waddr[p]] = wdata[p];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] <= '0;                            // whole file reads zero
         end
      end else begin
         regs <= regs_nxt;
      end
   end

   //************************************************
   // read ports
   //************************************************
   // raw stored words, enable and bypass are
   // applied downstream in the operand stage
   always_comb begin
      for (int n = 0; n < NUM_RD_PORTS; n++) begin
         rdata[n] = regs[raddr[n]];
      end
   end

endmodule

`default_nettype wire

// ==== logic/arf_operand_bypass.sv ====
//************************************************
// arf_operand_bypass
// per operand file select, same-cycle write
// forwarding and read enable masking
//************************************************

`timescale 1ns/1ps
`default_nettype none

module arf_operand_bypass (
   input  arf_pkg::reg_addr_t    raddr     [arf_pkg::NUM_RD_PORTS],
   input  logic [arf_pkg::NUM_RD_PORTS-1:0] ren,      // operand valid
   input  logic [arf_pkg::NUM_RD_PORTS-1:0] rfp,      // operand reads fpr

   input  arf_pkg::gpr_word_t    gpr_rdata [arf_pkg::NUM_RD_PORTS],
   input  arf_pkg::fpr_word_t    fpr_rdata [arf_pkg::NUM_RD_PORTS],

   input  logic [arf_pkg::GPR_WR_PORTS-1:0] gpr_wen,  // already x0 filtered
   input  arf_pkg::reg_addr_t    gpr_waddr [arf_pkg::GPR_WR_PORTS],
   input  arf_pkg::gpr_word_t    gpr_wdata [arf_pkg::GPR_WR_PORTS],

   input  logic [arf_pkg::FPR_WR_PORTS-1:0] fpr_wen,
   input  arf_pkg::reg_addr_t    fpr_waddr [arf_pkg::FPR_WR_PORTS],
   input  arf_pkg::fpr_word_t    fpr_wdata [arf_pkg::FPR_WR_PORTS],

   output arf_pkg::gpr_word_t    rdata     [arf_pkg::NUM_RD_PORTS]
);

   import arf_pkg::*;

   logic [NUM_RD_PORTS-1:0] gpr_hit;                  // gpr write to this index now
   logic [NUM_RD_PORTS-1:0] fpr_hit;
   gpr_word_t               gpr_fwd [NUM_RD_PORTS];   // winning gpr write data
   fpr_word_t               fpr_fwd [NUM_RD_PORTS];

   //************************************************
   // forward match, highest priority port first
   //************************************************
   always_comb begin
      for (int n = 0; n < NUM_RD_PORTS; n++) begin
         gpr_hit[n] = 1'b0;
         gpr_fwd[n] = '0;
         for (int p = GPR_WR_PORTS - 1; p >= 0; p--) begin    // load first, then i1, i0
            if (!gpr_hit[n] && gpr_wen[p] && (gpr_waddr[p] == raddr[n])) begin
               gpr_hit[n] = 1'b1;
               gpr_fwd[n] = gpr_wdata[p];
            end
         end
      end
   end

   always_comb begin
      for (int n = 0; n < NUM_RD_PORTS; n++) begin
         fpr_hit[n] = 1'b0;
         fpr_fwd[n] = '0;
         for (int p = FPR_WR_PORTS - 1; p >= 0; p--) begin    // load before i0
            if (!fpr_hit[n] && fpr_wen[p] && (fpr_waddr[p] == raddr[n])) begin
               fpr_hit[n] = 1'b1;
               fpr_fwd[n] = fpr_wdata[p];
            end
         end
      end
   end

   //************************************************
   // final operand mux
   //************************************************
   always_comb begin
      for (int n = 0; n < NUM_RD_PORTS; n++) begin
         if (!ren[n]) begin
            rdata[n] = '0;                            // unused operand reads zero
         end else if (rfp[n]) begin
            rdata[n] = fpr_hit[n] ? fpr_fwd[n] : fpr_rdata[n];  // FLEN == XLEN
         end else begin
            rdata[n] = gpr_hit[n] ? gpr_fwd[n] : gpr_rdata[n];
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/arf_top.sv ====
//************************************************
// arf_top
// dual-issue architectural register file
// write router, GPR and FPR side by side,
// operand stage with same-cycle forwarding
//************************************************

`timescale 1ns/1ps
`default_nettype none

module arf_top (
   input  logic                  clk,
   input  logic                  rst_n,

   // decode operand reads
   input  arf_pkg::reg_addr_t    i0_rs1_addr,
   input  logic                  i0_rs1_en,
   input  logic                  i0_rs1_fp,     // read fpr instead of gpr
   input  arf_pkg::reg_addr_t    i0_rs2_addr,
   input  logic                  i0_rs2_en,
   input  logic                  i0_rs2_fp,
   input  arf_pkg::reg_addr_t    i1_rs1_addr,
   input  logic                  i1_rs1_en,
   input  logic                  i1_rs1_fp,
   input  arf_pkg::reg_addr_t    i1_rs2_addr,
   input  logic                  i1_rs2_en,
   input  logic                  i1_rs2_fp,

   // slot-0 writeback
   input  logic                  i0_wen,
   input  logic                  i0_fp,
   input  arf_pkg::reg_addr_t    i0_waddr,
   input  arf_pkg::gpr_word_t    i0_wdata,

   // slot-1 writeback
   input  logic                  i1_wen,
   input  arf_pkg::reg_addr_t    i1_waddr,
   input  arf_pkg::gpr_word_t    i1_wdata,

   // nonblock load return
   input  logic                  nbl_wen,
   input  logic                  nbl_fp,
   input  arf_pkg::reg_addr_t    nbl_waddr,
   input  arf_pkg::gpr_word_t    nbl_wdata,

   output arf_pkg::gpr_word_t    i0_rs1_data,
   output arf_pkg::gpr_word_t    i0_rs2_data,
   output arf_pkg::gpr_word_t    i1_rs1_data,
   output arf_pkg::gpr_word_t    i1_rs2_data
);

   import arf_pkg::*;

   logic [GPR_WR_PORTS-1:0] gpr_wen;                  // router to files and bypass
   reg_addr_t               gpr_waddr [GPR_WR_PORTS];
   gpr_word_t               gpr_wdata [GPR_WR_PORTS];
   logic [FPR_WR_PORTS-1:0] fpr_wen;
   reg_addr_t               fpr_waddr [FPR_WR_PORTS];
   fpr_word_t               fpr_wdata [FPR_WR_PORTS];

   reg_addr_t               rd_addr   [NUM_RD_PORTS]; // shared by both files
   logic [NUM_RD_PORTS-1:0] rd_en;
   logic [NUM_RD_PORTS-1:0] rd_fp;
   gpr_word_t               gpr_rdata [NUM_RD_PORTS]; // raw stored words
   fpr_word_t               fpr_rdata [NUM_RD_PORTS];
   gpr_word_t               rd_data   [NUM_RD_PORTS];

   //************************************************
   // operand port packing
   //************************************************
   assign rd_addr[RD_I0_RS1] = i0_rs1_addr;
   assign rd_addr[RD_I0_RS2] = i0_rs2_addr;
   assign rd_addr[RD_I1_RS1] = i1_rs1_addr;
   assign rd_addr[RD_I1_RS2] = i1_rs2_addr;

   assign rd_en = {i1_rs2_en, i1_rs1_en, i0_rs2_en, i0_rs1_en};  // RD_* order
   assign rd_fp = {i1_rs2_fp, i1_rs1_fp, i0_rs2_fp, i0_rs1_fp};

   assign i0_rs1_data = rd_data[RD_I0_RS1];
   assign i0_rs2_data = rd_data[RD_I0_RS2];
   assign i1_rs1_data = rd_data[RD_I1_RS1];
   assign i1_rs2_data = rd_data[RD_I1_RS2];

   //************************************************
   // instances
   //************************************************
   arf_write_router u_router (.*);

   arf_regfile #(.data_t(gpr_word_t), .WR_PORTS(GPR_WR_PORTS)) gpr_rf (
      .clk, .rst_n,
      .wen(gpr_wen), .waddr(gpr_waddr), .wdata(gpr_wdata),
      .raddr(rd_addr), .rdata(gpr_rdata)
   );

   arf_regfile #(.data_t(fpr_word_t), .WR_PORTS(FPR_WR_PORTS)) fpr_rf (
      .clk, .rst_n,
      .wen(fpr_wen), .waddr(fpr_waddr), .wdata(fpr_wdata),
      .raddr(rd_addr), .rdata(fpr_rdata)
   );

   arf_operand_bypass u_bypass (
      .raddr(rd_addr), .ren(rd_en), .rfp(rd_fp),
      .gpr_rdata, .fpr_rdata,
      .gpr_wen, .gpr_waddr, .gpr_wdata,
      .fpr_wen, .fpr_waddr, .fpr_wdata,
      .rdata(rd_data)
   );

endmodule

`default_nettype wire

// ==== tb/arf_assertions.sv ====
//************************************************
// arf_assertions
// bound checks on the router write ports and
// the operand stage results inside arf_top
//************************************************

`timescale 1ns/1ps
`default_nettype none

module arf_assertions (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [arf_pkg::GPR_WR_PORTS-1:0] gpr_wen,      // router gpr enables
   input  arf_pkg::reg_addr_t    gpr_waddr [arf_pkg::GPR_WR_PORTS],
   input  logic [arf_pkg::NUM_RD_PORTS-1:0] ren,          // bypass operand enables
   input  arf_pkg::gpr_word_t    rdata     [arf_pkg::NUM_RD_PORTS]
);

   import arf_pkg::*;

   for (genvar p = 0; p < GPR_WR_PORTS; p++) begin : g_wport
      a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
         gpr_wen[p] |-> (gpr_waddr[p] != '0))           // x0 never reaches a file
         else $error("gpr write port %0d enabled with index 0", p);
   end

   for (genvar n = 0; n < NUM_RD_PORTS; n++) begin : g_rport
      a_off_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
         !ren[n] |-> (rdata[n] == '0))
         else $error("operand %0d disabled but data is %h", n, rdata[n]);
   end

endmodule

// router outputs and bypass results as wired in the top level
bind arf_top arf_assertions u_sva (
   .clk(clk), .rst_n(rst_n), .gpr_wen(gpr_wen), .gpr_waddr(gpr_waddr),
   .ren(rd_en), .rdata(rd_data)
);

`default_nettype wire

// ==== tb/arf_tb.sv ====
//************************************************
// arf_tb
// directed and random tests of the dual-issue
// register file against a reference model
//************************************************

`timescale 1ns/1ps
`default_nettype none

module arf_tb;

   import arf_pkg::*;

   logic        clk;
   logic        rst_n;
   reg_addr_t   ra [NUM_RD_PORTS];                    // operand indices
   logic [3:0]  ren;
   logic [3:0]  rfp;
   gpr_word_t   rd [NUM_RD_PORTS];                    // operand data from dut
   logic        i0_wen, i0_fp, i1_wen, nbl_wen, nbl_fp;
   reg_addr_t   i0_waddr, i1_waddr, nbl_waddr;
   gpr_word_t   i0_wdata, i1_wdata, nbl_wdata;
   gpr_word_t   gpr_m [NUM_REGS];                     // reference files
   fpr_word_t   fpr_m [NUM_REGS];
   gpr_word_t   rng;
   int          errors, checks, tests;
   string       rd_name [NUM_RD_PORTS] = '{"i0_rs1_data", "i0_rs2_data",
                                           "i1_rs1_data", "i1_rs2_data"};

   arf_top dut0 (
      .clk(clk), .rst_n(rst_n),
      .i0_rs1_addr(ra[0]), .i0_rs1_en(ren[0]), .i0_rs1_fp(rfp[0]),
      .i0_rs2_addr(ra[1]), .i0_rs2_en(ren[1]), .i0_rs2_fp(rfp[1]),
      .i1_rs1_addr(ra[2]), .i1_rs1_en(ren[2]), .i1_rs1_fp(rfp[2]),
      .i1_rs2_addr(ra[3]), .i1_rs2_en(ren[3]), .i1_rs2_fp(rfp[3]),
      .i0_wen(i0_wen), .i0_fp(i0_fp), .i0_waddr(i0_waddr), .i0_wdata(i0_wdata),
      .i1_wen(i1_wen), .i1_waddr(i1_waddr), .i1_wdata(i1_wdata),
      .nbl_wen(nbl_wen), .nbl_fp(nbl_fp), .nbl_waddr(nbl_waddr), .nbl_wdata(nbl_wdata),
      .i0_rs1_data(rd[0]), .i0_rs2_data(rd[1]), .i1_rs1_data(rd[2]), .i1_rs2_data(rd[3])
   );

   always #5 clk = ~clk;                              // 10 ns period

   function automatic gpr_word_t xorshift();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // value of one register once this cycle's writes land, later source wins
   function automatic gpr_word_t next_val(input logic f, input reg_addr_t a);
      gpr_word_t v;
      v = f ? fpr_m[a] : gpr_m[a];
      if (f) begin
         if (i0_wen && i0_fp && i0_waddr == a) v = i0_wdata;
         if (nbl_wen && nbl_fp && nbl_waddr == a) v = nbl_wdata;
      end else if (a != 5'd0) begin                   // x0 writes dropped
         if (i0_wen && !i0_fp && i0_waddr == a) v = i0_wdata;
         if (i1_wen && i1_waddr == a) v = i1_wdata;
         if (nbl_wen && !nbl_fp && nbl_waddr == a) v = nbl_wdata;
      end
      return v;
   endfunction

   // check all operands, then clock the model at the rising edge
   task automatic cycle();
      gpr_word_t exp;
      #1;
      for (int n = 0; n < NUM_RD_PORTS; n++) begin
         exp = ren[n] ? next_val(rfp[n], ra[n]) : '0;   // forwarded or stored
         checks++;
         if (rd[n] !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", rd_name[n], rd[n], exp);
         end
      end
      @(posedge clk);
      for (int a = 0; a < NUM_REGS; a++) begin
         gpr_m[a] = next_val(1'b0, reg_addr_t'(a));
         fpr_m[a] = next_val(1'b1, reg_addr_t'(a));
      end
      @(negedge clk);
   endtask

   task automatic set_reads(input int a0, a1, a2, a3, input logic [3:0] en, fp);
      ra[0] = reg_addr_t'(a0);
      ra[1] = reg_addr_t'(a1);
      ra[2] = reg_addr_t'(a2);
      ra[3] = reg_addr_t'(a3);
      ren = en;
      rfp = fp;
   endtask

   task automatic clear_writes();
      i0_wen = 1'b0;
      i1_wen = 1'b0;
      nbl_wen = 1'b0;
   endtask

   task automatic put_i0(input logic f, input int a);
      i0_wen = 1'b1;
      i0_fp = f;
      i0_waddr = reg_addr_t'(a);
      i0_wdata = xorshift();
   endtask

   task automatic put_i1(input int a);
      i1_wen = 1'b1;
      i1_waddr = reg_addr_t'(a);
      i1_wdata = xorshift();
   endtask

   task automatic put_nbl(input logic f, input int a);
      nbl_wen = 1'b1;
      nbl_fp = f;
      nbl_waddr = reg_addr_t'(a);
      nbl_wdata = xorshift();
   endtask

   task automatic report_test(input string name, input int e0);
      tests++;
      $display("test %-10s done, %0d errors", name, errors - e0);
   endtask

   //************************************************
   // tests
   //************************************************
   task automatic test_reset();
      int e0;
      int t;
      e0 = errors;
      t = 0;
      set_reads(1, 2, 3, 4, 4'hf, 4'h0);
      #1;
      while (((rd[0] | rd[1] | rd[2] | rd[3]) != '0) && (t < 10)) begin
         @(negedge clk);
         t++;
      end
      if (t >= 10) begin
         errors++;
         $display("read outputs did not settle to zero after reset");
      end
      @(negedge clk);                                 // back on the falling edge
      for (int k = 0; k < NUM_REGS; k++) begin
         set_reads(k, k, k, k, 4'hf, 4'b1010);        // both files at every index
         cycle();
      end
      set_reads(3, 9, 17, 30, 4'h0, 4'b0101);
      cycle();
      report_test("reset", e0);
   endtask

   task automatic test_gpr_write();
      int e0;
      e0 = errors;
      for (int k = 1; k < 16; k++) begin
         put_i0(1'b0, k);
         put_i1(k + 16);
         set_reads(k, k + 16, k + 16, k, 4'hf, 4'h0);
         cycle();
         clear_writes();
         set_reads(k, k, k, k, 4'hf, 4'h0);
         cycle();                                     // stored readback
         set_reads(k + 16, k + 16, k + 16, k + 16, 4'hf, 4'h0);
         cycle();
      end
      put_i0(1'b0, 0);                                // x0 from every source
      put_i1(0);
      put_nbl(1'b0, 0);
      set_reads(0, 0, 0, 0, 4'hf, 4'h0);
      cycle();
      clear_writes();
      cycle();
      report_test("gpr_write", e0);
   endtask

   task automatic test_file_sep();
      int e0;
      e0 = errors;
      for (int k = 0; k < NUM_REGS; k += 13) begin    // includes f0
         put_i0(1'b1, k);
         put_nbl(1'b0, k);
         set_reads(k, k, k, k, 4'hf, 4'b0101);
         cycle();
         clear_writes();
         cycle();
         set_reads(k, k, k, k, 4'hf, 4'b1010);
         cycle();
      end
      report_test("file_sep", e0);
   endtask

   task automatic test_forward();
      int e0;
      e0 = errors;
      for (int k = 1; k < NUM_REGS; k += 5) begin
         put_i1(k);
         set_reads(k, k, k, k, 4'b0111, 4'b0010);     // fpr side must not see it
         cycle();
         clear_writes();
         put_i0(1'b1, k);
         set_reads(k, k, k, k, 4'hf, 4'b0101);
         cycle();
         clear_writes();
      end
      report_test("forward", e0);
   endtask

   task automatic test_priority();
      int e0;
      e0 = errors;
      for (int k = 1; k < NUM_REGS; k += 6) begin
         put_i0(1'b0, k);
         put_i1(k);
         put_nbl(1'b0, k);                            // load should win
         set_reads(k, k, k, k, 4'hf, 4'h0);
         cycle();
         clear_writes();
         cycle();
         put_i0(1'b1, k);
         put_nbl(1'b1, k);
         set_reads(k, k, k, k, 4'hf, 4'hf);
         cycle();
         clear_writes();
         cycle();
      end
      report_test("priority", e0);
   endtask

   task automatic test_random();
      int e0;
      gpr_word_t r;
      gpr_word_t s;
      e0 = errors;
      for (int c = 0; c < 200; c++) begin
         r = xorshift();
         s = xorshift();
         i0_wen = r[0];
         i0_fp = r[1];
         i0_waddr = r[6:2];
         i1_wen = r[7];
         i1_waddr = r[12:8];
         nbl_wen = r[13];
         nbl_fp = r[14];
         nbl_waddr = r[19:15];
         i0_wdata = xorshift();
         i1_wdata = xorshift();
         nbl_wdata = xorshift();
         set_reads(s[4:0], s[9:5], s[14:10], s[19:15], r[23:20], r[27:24]);
         cycle();
      end
      clear_writes();
      report_test("random", e0);
   endtask

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      rng = 32'd89787;
      errors = 0;
      checks = 0;
      tests = 0;
      i0_fp = 1'b0;
      nbl_fp = 1'b0;
      i0_waddr = '0;
      i1_waddr = '0;
      nbl_waddr = '0;
      i0_wdata = '0;
      i1_wdata = '0;
      nbl_wdata = '0;
      clear_writes();
      set_reads(0, 0, 0, 0, 4'h0, 4'h0);
      for (int a = 0; a < NUM_REGS; a++) begin
         gpr_m[a] = '0;
         fpr_m[a] = '0;
      end
      repeat (5) @(posedge clk);                      // 5 cycles of reset
      @(negedge clk);
      rst_n = 1'b1;
      test_reset();
      test_gpr_write();
      test_file_sep();
      test_forward();
      test_priority();
      test_random();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== arf.f ====
logic/arf_pkg.sv
logic/arf_write_router.sv
logic/arf_regfile.sv
logic/arf_operand_bypass.sv
logic/arf_top.sv
tb/arf_assertions.sv
tb/arf_tb.sv

// ==== Makefile ====
# Verilator flow for the register file testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module arf_tb -f arf.f -o arf_sim

run: compile
	./obj_dir/arf_sim | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
